// ==== char_codes_pkg.sv ====
// Character codes: character type, ASCII control codes and decoded write commands
package char_codes_pkg;

  typedef logic [7:0] char_t;

  // Control codes the writer acts on
  localparam char_t ASCII_BS  = 8'h08;  // Backspace
  localparam char_t ASCII_HT  = 8'h09;  // Horizontal tab
  localparam char_t ASCII_LF  = 8'h0A;  // Line feed
  localparam char_t ASCII_CR  = 8'h0D;  // Carriage return
  localparam char_t ASCII_SP  = 8'h20;  // First printable code
  localparam char_t ASCII_DEL = 8'h7F;  // Delete, ignored

  // Cell content after clear, fill or backspace
  localparam char_t CHAR_BLANK = 8'h00;

  // What the writer does with one incoming code
  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_PUT     = 3'd1,
    CMD_BACK    = 3'd2,
    CMD_NEWLINE = 3'd3,
    CMD_TAB     = 3'd4
  } char_cmd_t;

endpackage

// ==== char_console.f ====
+incdir+.
char_codes_pkg.sv
console_pkg.sv
char_ram.sv
write_cursor.sv
frame_scanner.sv
console_ctrl.sv
char_console_top.sv
tb_char_console.sv

// ==== char_console_top.sv ====
// Text console buffer top level joining control, cursor, scanner and cell memory
`timescale 1ns/1ns
`include "console_cfg.svh"

module char_console_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_char_stb,
  input  char_codes_pkg::char_t    i_char,
  input  logic [`CON_TAB_BITS-1:0] i_tab_count,
  input  logic                     i_alt_func_en,
  input  logic                     i_clear_screen_stb,
  input  logic                     i_read_frame_stb,
  input  logic                     i_char_req_en,
  output logic                     o_char_rdy,
  output char_codes_pkg::char_t    o_char
);
  import char_codes_pkg::*;
  import console_pkg::*;

  // Cursor commands
  logic  cur_put;
  logic  cur_back;
  logic  cur_newline_step;
  logic  cur_tab_load;
  logic  cur_clear_step;
  logic  cur_clear_done;
  // Cursor status
  logic  at_line_end;
  logic  tab_done;
  logic  clear_last;
  logic  scrolled;
  addr_t wr_addr;
  addr_t row_start;
  // Memory and scanner
  logic  we;
  char_t wr_data;
  logic  scan_start;
  logic  scan_step;
  logic  frame_done;
  addr_t rd_addr;

  console_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .i_at_line_end      (at_line_end),
    .i_tab_done         (tab_done),
    .i_clear_last       (clear_last),
    .i_frame_done       (frame_done),
    .o_cur_put          (cur_put),
    .o_cur_back         (cur_back),
    .o_cur_newline_step (cur_newline_step),
    .o_cur_tab_load     (cur_tab_load),
    .o_cur_clear_step   (cur_clear_step),
    .o_cur_clear_done   (cur_clear_done),
    .o_we               (we),
    .o_wr_data          (wr_data),
    .o_scan_start       (scan_start),
    .o_scan_step        (scan_step),
    .o_char_rdy         (o_char_rdy)
  );

  write_cursor u_cursor (
    .clk            (clk),
    .rst            (rst),
    .i_put          (cur_put),
    .i_back         (cur_back),
    .i_newline_step (cur_newline_step),
    .i_tab_load     (cur_tab_load),
    .i_tab_count    (i_tab_count),
    .i_clear_step   (cur_clear_step),
    .i_clear_done   (cur_clear_done),
    .o_wr_addr      (wr_addr),
    .o_row_start    (row_start),
    .o_at_line_end  (at_line_end),
    .o_tab_done     (tab_done),
    .o_clear_last   (clear_last),
    .o_scrolled     (scrolled)
  );

  frame_scanner u_scanner (
    .clk          (clk),
    .rst          (rst),
    .i_scan_start (scan_start),
    .i_scan_step  (scan_step),
    .i_row_start  (row_start),
    .i_scrolled   (scrolled),
    .o_rd_addr    (rd_addr),
    .o_frame_done (frame_done)
  );

  char_ram u_ram (
    .clk       (clk),
    .rst       (rst),
    .i_we      (we),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_char)
  );

endmodule

// ==== char_ram.sv ====
// Character cell memory with one write port and a registered read port
`timescale 1ns/1ns
`include "console_cfg.svh"

module char_ram (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_we,
  input  console_pkg::addr_t    i_wr_addr,
  input  char_codes_pkg::char_t i_wr_data,
  input  console_pkg::addr_t    i_rd_addr,
  output char_codes_pkg::char_t o_rd_data
);
  import char_codes_pkg::*;

  char_t mem [0:(1 << `CON_ADDR_BITS) - 1];

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];  // Data valid one cycle after the address
  end

  // A write must always land on a known cell
  a_wr_addr_known : assert property (
    @(posedge clk) disable iff (rst)
    i_we |-> !$isunknown(i_wr_addr)
  ) else $error("char_ram: write with unknown address");

endmodule

// ==== console_cfg.svh ====
// Console configuration macros for buffer depth, text image size and font height
`ifndef CONSOLE_CFG_SVH
`define CONSOLE_CFG_SVH

// Cell address width, 64 cells in the ring
`define CON_ADDR_BITS    6

// Visible text image
`define CON_IMG_WIDTH    8    // Characters per text row
`define CON_IMG_HEIGHT   4    // Visible text rows

// Scanlines sent for every text row
`define CON_FONT_HEIGHT  2

// Width of the tab blank count
`define CON_TAB_BITS     3

`endif

// ==== console_ctrl.sv ====
// Console control: code decoding, writer and scanner FSMs and clear sequencing
`timescale 1ns/1ns

module console_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_char_stb,
  input  char_codes_pkg::char_t i_char,
  input  logic                  i_alt_func_en,
  input  logic                  i_clear_screen_stb,
  input  logic                  i_read_frame_stb,
  input  logic                  i_char_req_en,
  input  logic                  i_at_line_end,
  input  logic                  i_tab_done,
  input  logic                  i_clear_last,
  input  logic                  i_frame_done,
  output logic                  o_cur_put,
  output logic                  o_cur_back,
  output logic                  o_cur_newline_step,
  output logic                  o_cur_tab_load,
  output logic                  o_cur_clear_step,
  output logic                  o_cur_clear_done,
  output logic                  o_we,
  output char_codes_pkg::char_t o_wr_data,
  output logic                  o_scan_start,
  output logic                  o_scan_step,
  output logic                  o_char_rdy
);
  import char_codes_pkg::*;
  import console_pkg::*;

  wr_state_t  wr_state;
  rd_state_t  rd_state;
  char_t      r_char;
  logic       r_fill_tab;    // Fill in progress is a tab, not a newline
  logic       r_clear_pend;
  logic [1:0] r_clear_tail;
  char_cmd_t  cmd;
  logic       accept;

  function automatic char_cmd_t decode(input char_t c, input logic alt);
    char_cmd_t cmd_d;
    cmd_d = CMD_PUT;
    if (!alt) begin  // Raw write skips decoding
      case (c)
        ASCII_BS:           cmd_d = CMD_BACK;
        ASCII_HT:           cmd_d = CMD_TAB;
        ASCII_LF, ASCII_CR: cmd_d = CMD_NEWLINE;
        ASCII_DEL:          cmd_d = CMD_NONE;
        default: begin
          if (c < ASCII_SP) begin
            cmd_d = CMD_NONE;
          end
        end
      endcase
    end
    return cmd_d;
  endfunction

  assign cmd    = decode(i_char, i_alt_func_en);
  assign accept = i_char_stb && (wr_state == WR_IDLE) && !r_clear_pend;

  assign o_cur_put          = (wr_state == WR_PUT) || (wr_state == WR_FILL && r_fill_tab);
  assign o_cur_back         = (wr_state == WR_BACK);
  assign o_cur_newline_step = (wr_state == WR_FILL) && !r_fill_tab;
  assign o_cur_tab_load     = accept && (cmd == CMD_TAB);
  assign o_cur_clear_step   = (wr_state == WR_CLEAR) && (r_clear_tail == 2'd0);
  assign o_cur_clear_done   = (wr_state == WR_CLEAR) && (r_clear_tail == 2'd2);
  assign o_we      = o_cur_put || o_cur_back || o_cur_newline_step || o_cur_clear_step;
  assign o_wr_data = (wr_state == WR_PUT) ? r_char : CHAR_BLANK;

  assign o_scan_start = (rd_state == RD_PREP);
  assign o_scan_step  = (rd_state == RD_GAP);   // Advance once the read has landed
  assign o_char_rdy   = (rd_state == RD_GAP);

  always_ff @(posedge clk) begin
    if (accept) begin
      r_char <= i_char;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state     <= WR_CLEAR;
      r_fill_tab   <= 1'b0;
      r_clear_pend <= 1'b0;
      r_clear_tail <= 2'd0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (r_clear_pend && rd_state == RD_IDLE) begin
            r_clear_pend <= 1'b0;
            wr_state     <= WR_CLEAR;
          end else if (accept) begin
            case (cmd)
              CMD_PUT:  wr_state <= WR_PUT;
              CMD_BACK: wr_state <= WR_BACK;
              CMD_NEWLINE: begin
                r_fill_tab <= 1'b0;
                wr_state   <= WR_FILL;
              end
              CMD_TAB: begin
                r_fill_tab <= 1'b1;
                if (!i_tab_done) begin  // Zero count writes nothing
                  wr_state <= WR_FILL;
                end
              end
              default: wr_state <= WR_IDLE;
            endcase
          end
        end
        WR_PUT:  wr_state <= WR_IDLE;
        WR_BACK: wr_state <= WR_IDLE;
        WR_FILL: begin
          if (r_fill_tab ? i_tab_done : i_at_line_end) begin
            wr_state <= WR_IDLE;
          end
        end
        WR_CLEAR: begin
          // Two settle cycles after the last cell
          if (r_clear_tail != 2'd0 || i_clear_last) begin
            r_clear_tail <= r_clear_tail + 2'd1;
          end
          if (r_clear_tail == 2'd2) begin
            r_clear_tail <= 2'd0;
            wr_state     <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase

      if (i_clear_screen_stb) begin
        r_clear_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else if (i_read_frame_stb) begin
      rd_state <= RD_WAIT;  // Restart from the top
    end else begin
      case (rd_state)
        RD_WAIT: begin
          if (wr_state == WR_IDLE) begin
            rd_state <= RD_PREP;
          end
        end
        RD_PREP: rd_state <= RD_GET;
        RD_GET: begin
          if (i_char_req_en) begin
            rd_state <= RD_GAP;
          end
        end
        RD_GAP:  rd_state <= i_frame_done ? RD_IDLE : RD_GET;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Scanner output must never overlap a buffer clear
  a_no_rdy_in_clear : assert property (
    @(posedge clk) disable iff (rst)
    !(o_char_rdy && wr_state == WR_CLEAR)
  ) else $error("console_ctrl: character output during clear");

endmodule

// ==== console_pkg.sv ====
// Console types: cell address, column index and the writer and scanner states
`include "console_cfg.svh"

package console_pkg;

  typedef logic [`CON_ADDR_BITS-1:0] addr_t;
  typedef logic [2:0]                col_t;

  // Writer FSM, reset enters the clear sequence
  typedef enum logic [2:0] {
    WR_CLEAR = 3'd0,
    WR_IDLE  = 3'd1,
    WR_PUT   = 3'd2,
    WR_FILL  = 3'd3,  // Newline or tab blanks
    WR_BACK  = 3'd4
  } wr_state_t;

  // Frame scanner FSM
  typedef enum logic [2:0] {
    RD_IDLE = 3'd0,
    RD_WAIT = 3'd1,  // Hold off until writer is idle
    RD_PREP = 3'd2,
    RD_GET  = 3'd3,
    RD_GAP  = 3'd4
  } rd_state_t;

endpackage

// ==== frame_scanner.sv ====
// Frame scanner: frame start, raster counters and the read address of each cell
`timescale 1ns/1ns
`include "console_cfg.svh"

module frame_scanner (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_scan_start,
  input  logic               i_scan_step,
  input  console_pkg::addr_t i_row_start,
  input  logic               i_scrolled,
  output console_pkg::addr_t o_rd_addr,
  output logic               o_frame_done
);
  import console_pkg::*;

  localparam int    ROW_BITS  = $clog2(`CON_IMG_HEIGHT);
  localparam int    SCAN_BITS = (`CON_FONT_HEIGHT > 1) ? $clog2(`CON_FONT_HEIGHT) : 1;
  localparam addr_t ROW_STEP  = addr_t'(`CON_IMG_WIDTH);
  localparam addr_t WIN_SPAN  = addr_t'((`CON_IMG_HEIGHT - 1) * `CON_IMG_WIDTH);
  localparam col_t  LAST_COL  = col_t'(`CON_IMG_WIDTH - 1);

  addr_t                r_rd_addr;
  addr_t                r_row_base;  // First cell of the text row in flight
  col_t                 r_col;
  logic [SCAN_BITS-1:0] r_scan;
  logic [ROW_BITS-1:0]  r_row;
  addr_t                frame_start;
  logic                 row_end;
  logic                 scan_end;

  // Window follows the cursor row once scrolled
  assign frame_start  = i_scrolled ? i_row_start - WIN_SPAN : '0;
  assign row_end      = (r_col == LAST_COL);
  assign scan_end     = (r_scan == SCAN_BITS'(`CON_FONT_HEIGHT - 1));
  assign o_frame_done = i_scan_step && row_end && scan_end &&
                        (r_row == ROW_BITS'(`CON_IMG_HEIGHT - 1));
  assign o_rd_addr    = r_rd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_rd_addr  <= '0;
      r_row_base <= '0;
      r_col      <= '0;
      r_scan     <= '0;
      r_row      <= '0;
    end else if (i_scan_start) begin
      r_rd_addr  <= frame_start;
      r_row_base <= frame_start;
      r_col      <= '0;
      r_scan     <= '0;
      r_row      <= '0;
    end else if (i_scan_step) begin
      if (!row_end) begin
        r_col     <= r_col + 1'b1;
        r_rd_addr <= r_rd_addr + addr_t'(1);
      end else begin
        r_col <= '0;
        if (!scan_end) begin
          // Same text row again for the next scanline
          r_scan    <= r_scan + 1'b1;
          r_rd_addr <= r_row_base;
        end else begin
          r_scan     <= '0;
          r_row      <= r_row + 1'b1;
          r_row_base <= r_row_base + ROW_STEP;
          r_rd_addr  <= r_row_base + ROW_STEP;
        end
      end
    end
  end

endmodule

// ==== tb_char_console.sv ====
// Testbench for the text console buffer: random text, reference model and frame checks
`timescale 1ns/1ns
`include "console_cfg.svh"

module tb_char_console;
  import char_codes_pkg::*;
  import console_pkg::*;

  localparam int IMG_W        = `CON_IMG_WIDTH;
  localparam int IMG_H        = `CON_IMG_HEIGHT;
  localparam int FONT_H       = `CON_FONT_HEIGHT;
  localparam int CELLS        = 1 << `CON_ADDR_BITS;
  localparam int FRAME_PULSES = IMG_W * IMG_H * FONT_H;
  localparam int STB_GAP      = IMG_W + 6;
  localparam int FRAME_BOUND  = 2 * 64 + 10;
  localparam int FRAME_LIMIT  = 4 * FRAME_BOUND;  // Room for request-enable low periods
  localparam int CLEAR_WAIT   = CELLS + 8;
  localparam int N_STROBES    = 200;
  localparam int N_FRAMES     = 10;
  localparam int WDOG_CYCLES  = 4 * (N_STROBES * STB_GAP + N_FRAMES * FRAME_BOUND +
                                     3 * CLEAR_WAIT + 10);

  logic                     clk;
  logic                     rst;
  logic                     i_char_stb;
  char_t                    i_char;
  logic [`CON_TAB_BITS-1:0] i_tab_count;
  logic                     i_alt_func_en;
  logic                     i_clear_screen_stb;
  logic                     i_read_frame_stb;
  logic                     i_char_req_en;
  logic                     o_char_rdy;
  char_t                    o_char;

  // Reference model of the cell ring and cursor
  char_t m_mem [0:CELLS-1];
  addr_t m_pos;
  addr_t m_row_start;
  int    m_col;
  int    m_row;
  logic  m_scrolled;

  logic [15:0] lfsr = 16'd28057;
  char_t       rx_q[$];
  int          rx_cyc[$];
  int          cyc_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          err_mark = 0;
  char_t       ctl_codes [0:11];

  char_console_top dut (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_tab_count        (i_tab_count),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .o_char_rdy         (o_char_rdy),
    .o_char             (o_char)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic void advance_cursor();
    m_pos = m_pos + addr_t'(1);
    if (m_col == IMG_W - 1) begin
      m_col       = 0;
      m_row_start = m_row_start + addr_t'(IMG_W);
      if (!m_scrolled) begin
        m_row++;
        m_scrolled = (m_row == IMG_H - 1);  // Window follows from here on
      end
    end else begin
      m_col++;
    end
  endfunction

  function automatic void apply_code(input char_t c, input logic alt,
                                     input logic [`CON_TAB_BITS-1:0] tabs);
    logic last;
    if (alt || (c >= ASCII_SP && c != ASCII_DEL)) begin
      m_mem[m_pos] = c;
      advance_cursor();
    end else if (c == ASCII_BS) begin
      if (m_col != 0) begin  // Stops at the row start
        m_pos = m_pos - addr_t'(1);
        m_col--;
      end
      m_mem[m_pos] = CHAR_BLANK;
    end else if (c == ASCII_HT) begin
      for (int i = 0; i < tabs; i++) begin
        m_mem[m_pos] = CHAR_BLANK;
        advance_cursor();
      end
    end else if (c == ASCII_LF || c == ASCII_CR) begin
      do begin
        last         = (m_col == IMG_W - 1);
        m_mem[m_pos] = CHAR_BLANK;
        advance_cursor();
      end while (!last);
    end
  endfunction

  function automatic void blank_model();
    for (int i = 0; i < CELLS; i++) begin
      m_mem[i] = CHAR_BLANK;
    end
    m_pos       = '0;
    m_row_start = '0;
    m_col       = 0;
    m_row       = 0;
    m_scrolled  = 1'b0;
  endfunction

  task automatic check_char(input char_t actual, input char_t expected, input int idx);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t: char %0d expected %h got %h", $time, idx, expected, actual);
    end
  endtask

  task automatic check_count(input int actual, input int expected, input string what);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("[FAIL] %0t: %s expected %0d got %0d", $time, what, expected, actual);
    end
  endtask

  task automatic send_char(input char_t c, input logic alt,
                           input logic [`CON_TAB_BITS-1:0] tabs);
    @(posedge clk);
    i_char_stb    <= 1'b1;
    i_char        <= c;
    i_alt_func_en <= alt;
    i_tab_count   <= tabs;
    @(posedge clk);
    i_char_stb <= 1'b0;
    repeat (STB_GAP - 1) @(posedge clk);
    apply_code(c, alt, tabs);
  endtask

  task automatic send_text(input int n);
    for (int i = 0; i < n; i++) begin
      send_char(char_t'(8'h20 + rand_bits(7) % 95), 1'b0, '0);
    end
  endtask

  task automatic clear_screen();
    @(posedge clk);
    i_clear_screen_stb <= 1'b1;
    @(posedge clk);
    i_clear_screen_stb <= 1'b0;
    repeat (CLEAR_WAIT) @(posedge clk);
    blank_model();
  endtask

  task automatic read_frame(input logic vary_req, input logic check_gap);
    char_t exp_q[$];
    addr_t start;
    int    wait_cyc;
    start = m_scrolled ? addr_t'(m_row_start - addr_t'((IMG_H - 1) * IMG_W)) : '0;
    for (int r = 0; r < IMG_H; r++) begin
      for (int s = 0; s < FONT_H; s++) begin
        for (int c = 0; c < IMG_W; c++) begin
          exp_q.push_back(m_mem[addr_t'(start + addr_t'(r * IMG_W + c))]);
        end
      end
    end
    // No character output is expected between frames
    check_count(rx_q.size(), 0, "pulses outside a frame");
    rx_q.delete();
    rx_cyc.delete();
    wait_cyc = 0;
    @(posedge clk);
    i_read_frame_stb <= 1'b1;
    @(posedge clk);
    i_read_frame_stb <= 1'b0;
    while (rx_q.size() < FRAME_PULSES && wait_cyc < FRAME_LIMIT) begin
      @(posedge clk);
      if (vary_req) begin
        i_char_req_en <= (rand_bits(2) != 0);  // Low about one cycle in four
      end
      wait_cyc++;
    end
    i_char_req_en <= 1'b1;
    if (rx_q.size() < FRAME_PULSES) begin
      errors++;
      $display("Frame timed out with %0d of %0d characters received",
               rx_q.size(), FRAME_PULSES);
    end
    repeat (8) @(posedge clk);  // Catch any extra pulses
    check_count(rx_q.size(), FRAME_PULSES, "pulses per frame");
    for (int i = 0; i < rx_q.size() && i < FRAME_PULSES; i++) begin
      check_char(rx_q[i], exp_q[i], i);
      if (check_gap && i > 0) begin
        check_count(rx_cyc[i] - rx_cyc[i-1], 2, "pulse spacing");
      end
    end
    rx_q.delete();
    rx_cyc.delete();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  // Output monitor away from the driving edge
  always @(negedge clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (!rst && o_char_rdy) begin
      rx_q.push_back(o_char);
      rx_cyc.push_back(cyc_cnt);
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the run did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst                <= 1'b1;
    i_char_stb         <= 1'b0;
    i_char             <= '0;
    i_tab_count        <= '0;
    i_alt_func_en      <= 1'b0;
    i_clear_screen_stb <= 1'b0;
    i_read_frame_stb   <= 1'b0;
    i_char_req_en      <= 1'b1;
    blank_model();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (CLEAR_WAIT) @(posedge clk);  // Clear that follows reset

    read_frame(1'b0, 1'b1);
    finish_test("blank frame after reset");

    send_text(12);
    send_char(ASCII_CR, 1'b0, '0);
    send_text(5);
    send_char(ASCII_LF, 1'b0, '0);
    send_text(3);
    read_frame(1'b0, 1'b0);
    finish_test("printable text and newlines");

    send_char(ASCII_CR, 1'b0, '0);
    send_char(ASCII_HT, 1'b0, rand_bits(3));
    send_text(3);
    send_char(ASCII_HT, 1'b0, rand_bits(3));
    for (int i = 0; i < 10; i++) begin
      send_char(ASCII_BS, 1'b0, '0);  // More than the row holds
    end
    send_text(2);
    read_frame(1'b0, 1'b0);
    finish_test("tab and backspace");

    for (int i = 0; i < 12; i++) begin
      ctl_codes[i] = char_t'(rand_bits(5));
      if (ctl_codes[i] == ASCII_BS || ctl_codes[i] == ASCII_HT ||
          ctl_codes[i] == ASCII_LF || ctl_codes[i] == ASCII_CR) begin
        ctl_codes[i] = ASCII_DEL;
      end
      send_char(ctl_codes[i], 1'b0, '0);
    end
    for (int i = 0; i < 12; i++) begin
      send_char(ctl_codes[i], 1'b1, '0);
    end
    read_frame(1'b0, 1'b0);
    finish_test("ignored and raw control codes");

    // Tabs and newlines here also land on old text once the ring wraps
    for (int i = 0; i < 100; i++) begin
      case (rand_bits(3))
        0:       send_char(ASCII_LF, 1'b0, '0);
        1:       send_char(ASCII_HT, 1'b0, rand_bits(3));
        default: send_text(1);
      endcase
      if (i == 49 || i == 99) begin
        read_frame(1'b1, 1'b0);
      end
    end
    finish_test("scrolling window and back-pressure");

    clear_screen();
    read_frame(1'b0, 1'b0);
    send_text(10);
    read_frame(1'b1, 1'b0);
    finish_test("clear screen");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== write_cursor.sv ====
// Write cursor: write position, current row start, tab count and scroll state
`timescale 1ns/1ns
`include "console_cfg.svh"

module write_cursor (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_put,
  input  logic                     i_back,
  input  logic                     i_newline_step,
  input  logic                     i_tab_load,
  input  logic [`CON_TAB_BITS-1:0] i_tab_count,
  input  logic                     i_clear_step,
  input  logic                     i_clear_done,
  output console_pkg::addr_t       o_wr_addr,
  output console_pkg::addr_t       o_row_start,
  output logic                     o_at_line_end,
  output logic                     o_tab_done,
  output logic                     o_clear_last,
  output logic                     o_scrolled
);
  import console_pkg::*;

  localparam int    ROW_BITS = $clog2(`CON_IMG_HEIGHT);
  localparam addr_t ROW_STEP = addr_t'(`CON_IMG_WIDTH);
  localparam col_t  LAST_COL = col_t'(`CON_IMG_WIDTH - 1);

  addr_t                    r_pos;
  addr_t                    r_row_start;
  addr_t                    r_clear_addr;
  col_t                     r_col;
  logic [ROW_BITS-1:0]      r_row;
  logic                     r_scrolled;
  logic [`CON_TAB_BITS-1:0] r_tab_cnt;
  addr_t                    back_addr;
  logic                     advance;

  assign advance   = i_put || i_newline_step;
  // Backspace never leaves the current row
  assign back_addr = (r_col != '0) ? r_pos - addr_t'(1) : r_pos;

  assign o_wr_addr     = i_clear_step ? r_clear_addr :
                         i_back       ? back_addr    : r_pos;
  assign o_row_start   = r_row_start;
  assign o_at_line_end = (r_col == LAST_COL);
  assign o_clear_last  = &r_clear_addr;
  assign o_scrolled    = r_scrolled;
  // Look ahead so the last blank of a tab ends the fill
  assign o_tab_done    = i_tab_load ? (i_tab_count == '0) : (r_tab_cnt == 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      r_pos        <= '0;
      r_row_start  <= '0;
      r_clear_addr <= '0;
      r_col        <= '0;
      r_row        <= '0;
      r_scrolled   <= 1'b0;
      r_tab_cnt    <= '0;
    end else begin
      if (i_clear_step) begin
        r_clear_addr <= r_clear_addr + addr_t'(1);  // Wraps back to zero
      end

      if (i_tab_load) begin
        r_tab_cnt <= i_tab_count;
      end else if (i_put && r_tab_cnt != '0) begin
        r_tab_cnt <= r_tab_cnt - 1'b1;
      end

      if (i_clear_done) begin
        r_pos       <= '0;
        r_row_start <= '0;
        r_col       <= '0;
        r_row       <= '0;
        r_scrolled  <= 1'b0;
      end else if (advance) begin
        r_pos <= r_pos + addr_t'(1);
        if (r_col == LAST_COL) begin
          // Crossing into the next row
          r_col       <= '0;
          r_row_start <= r_row_start + ROW_STEP;
          if (!r_scrolled) begin
            r_row <= r_row + 1'b1;
            if (r_row == ROW_BITS'(`CON_IMG_HEIGHT - 2)) begin
              r_scrolled <= 1'b1;  // Cursor now on last visible row
            end
          end
        end else begin
          r_col <= r_col + 1'b1;
        end
      end else if (i_back && r_col != '0) begin
        r_pos <= back_addr;
        r_col <= r_col - 1'b1;
      end
    end
  end

  // Position stays inside the row that starts at r_row_start
  a_pos_in_row : assert property (
    @(posedge clk) disable iff (rst)
    addr_t'(r_pos - r_row_start) <= addr_t'(`CON_IMG_WIDTH)
  ) else $error("write_cursor: position outside current row");

endmodule
